//--- project.f
logic/rv_pkg.sv
logic/rv_ifs.sv
logic/inst_decode.sv
logic/exec_unit.sv
logic/data_ram.sv
logic/result_commit.sv
logic/rv_core.sv
sim/tb_rv_core.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --assert -j 0
TOP       := tb_rv_core
FILELIST  := project.f
BUILD_DIR := obj_dir
LOG       := sim.log
SRCS      := $(shell cat $(FILELIST))

.PHONY: all run lint clean

all: run

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: $(BUILD_DIR)/V$(TOP)
	@./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; st=$$?; cat $(LOG); \
	if [ $$st -ne 0 ] || grep -q "TESTS FAILED" $(LOG); then echo "simulation failed"; exit 1; fi

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- sim/tb_rv_core.sv
module tb_rv_core;
	import rv_pkg::*;

	typedef struct packed {
		word_t    pc;
		reg_idx_t rd;
		word_t    value;
		word_t    next_pc;
		logic     illegal;
		logic     has_value;  // op produces a result
	} retire_t;

	logic     clk = 1'b0;
	logic     arst_n;
	logic     instr_valid;
	word_t    instr;
	logic     retire_valid;
	word_t    retire_pc;
	reg_idx_t retire_rd;
	word_t    retire_value;
	word_t    retire_next_pc;
	logic     retire_illegal;

	int      seed = 79422;
	int      mismatches = 0;
	int      failures = 0;
	word_t   m_regs [32] = '{default: '0};  // reference model state
	word_t   m_ram [16] = '{default: '0};   // words 0 to 15 only
	word_t   m_pc = '0;
	retire_t exp_q [$];
	logic    iv_d1;
	logic    iv_d2;

	rv_core i_rv_core (
		.clk            (clk),
		.arst_n         (arst_n),
		.instr_valid    (instr_valid),
		.instr          (instr),
		.retire_valid   (retire_valid),
		.retire_pc      (retire_pc),
		.retire_rd      (retire_rd),
		.retire_value   (retire_value),
		.retire_next_pc (retire_next_pc),
		.retire_illegal (retire_illegal)
	);

	always #10 clk = ~clk;

	function automatic int rnd(int n);
		return $unsigned($random(seed)) % n;
	endfunction

	function automatic word_t encode(op_e op, reg_idx_t rd, reg_idx_t rs1, reg_idx_t rs2,
			word_t imm);
		case (op)
			OP_LUI:   return {imm[31:12], rd, OPC_LUI};
			OP_AUIPC: return {imm[31:12], rd, OPC_AUIPC};
			OP_JAL:   return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
			OP_JALR:  return {imm[11:0], rs1, 3'b000, rd, OPC_JALR};
			OP_LW:    return {imm[11:0], rs1, 3'b010, rd, OPC_LOAD};
			OP_SB:    return {imm[11:5], rs2, rs1, 3'b000, imm[4:0], OPC_STORE};
			OP_SH:    return {imm[11:5], rs2, rs1, 3'b001, imm[4:0], OPC_STORE};
			OP_SW:    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OPC_STORE};
			OP_ADDI:  return {imm[11:0], rs1, 3'b000, rd, OPC_IMM};
			OP_ADD:   return {7'b0000000, rs2, rs1, 3'b000, rd, OPC_REG};
			OP_SUB:   return {7'b0100000, rs2, rs1, 3'b000, rd, OPC_REG};
			OP_BEQ:   return {imm[12], imm[10:5], rs2, rs1, 3'b000, imm[4:1], imm[11], OPC_BRANCH};
			OP_BNE:   return {imm[12], imm[10:5], rs2, rs1, 3'b001, imm[4:1], imm[11], OPC_BRANCH};
			default: begin
				if (imm[1:0] == 2'd0)
					return {imm[31:7], 7'b0001111};  // fence space
				if (imm[1:0] == 2'd1)
					return {imm[31:15], 1'b1, imm[13:7], OPC_BRANCH};  // blt and up
				return {7'b0000001, imm[24:7], OPC_REG};  // mul family
			end
		endcase
	endfunction

	// advances the model by one instruction, returns what should retire
	function automatic retire_t model_step(op_e op, reg_idx_t rd, reg_idx_t rs1, reg_idx_t rs2,
			word_t imm);
		retire_t e;
		word_t   a;
		word_t   b;
		word_t   addr;
		a = m_regs[rs1];
		b = m_regs[rs2];
		addr = a + imm;
		e.pc = m_pc;
		e.next_pc = m_pc + 32'd4;
		e.value = '0;
		e.has_value = 1'b1;
		e.illegal = 1'b0;
		case (op)
			OP_LUI:          e.value = imm;
			OP_AUIPC:        e.value = m_pc + imm;
			OP_JAL, OP_JALR: e.value = m_pc + 32'd4;
			OP_LW:           e.value = m_ram[addr[5:2]];
			OP_ADDI:         e.value = addr;
			OP_ADD:          e.value = a + b;
			OP_SUB:          e.value = a - b;
			default:         e.has_value = 1'b0;
		endcase
		case (op)
			OP_JAL:     e.next_pc = m_pc + imm;
			OP_JALR:    e.next_pc = addr & ~32'd1;
			OP_BEQ:     e.next_pc = (a == b) ? m_pc + imm : e.next_pc;
			OP_BNE:     e.next_pc = (a != b) ? m_pc + imm : e.next_pc;
			OP_SB:      m_ram[addr[5:2]][{addr[1:0], 3'b000} +: 8] = b[7:0];
			OP_SH:      m_ram[addr[5:2]][{addr[1], 4'b0000} +: 16] = b[15:0];
			OP_SW:      m_ram[addr[5:2]] = b;
			OP_ILLEGAL: e.illegal = 1'b1;
			default:    e.illegal = 1'b0;
		endcase
		e.rd = e.has_value ? rd : 5'd0;
		if (e.has_value && rd != 5'd0)
			m_regs[rd] = e.value;  // x0 stays zero
		m_pc = e.next_pc;
		return e;
	endfunction

	task automatic issue(op_e op, reg_idx_t rd, reg_idx_t rs1, reg_idx_t rs2, word_t imm);
		retire_t e;
		e = model_step(op, rd, rs1, rs2, imm);
		@(posedge clk);
		instr_valid <= 1'b1;
		instr <= encode(op, rd, rs1, rs2, imm);
		exp_q.push_back(e);
	endtask

	task automatic idle(int n);
		repeat (n) begin
			@(posedge clk);
			instr_valid <= 1'b0;
		end
	endtask

	task automatic compare_field(string name, word_t got, word_t want);
		assert (got === want) else begin
			$display("MISMATCH %s: got %h expected %h", name, got, want);
			mismatches++;
		end
	endtask

	task automatic check_retire();
		retire_t e;
		if (exp_q.size() == 0) begin
			$display("retire seen with no instruction outstanding");
			failures++;
		end else begin
			e = exp_q.pop_front();
			compare_field("retire_pc", retire_pc, e.pc);
			compare_field("retire_rd", word_t'(retire_rd), word_t'(e.rd));
			compare_field("retire_next_pc", retire_next_pc, e.next_pc);
			compare_field("retire_illegal", word_t'(retire_illegal), word_t'(e.illegal));
			if (e.has_value)
				compare_field("retire_value", retire_value, e.value);
		end
	endtask

	// retire must trail each sampled strobe by one edge
	always @(posedge clk) begin
		if (!arst_n) begin
			iv_d1 <= 1'b0;
			iv_d2 <= 1'b0;
		end else begin
			assert (retire_valid === iv_d2) else begin
				$display("MISMATCH retire_valid: got %h expected %h", retire_valid, iv_d2);
				mismatches++;
			end
			if (retire_valid)
				check_retire();
			iv_d1 <= instr_valid;
			iv_d2 <= iv_d1;
		end
	end

	initial begin
		op_e      op;
		reg_idx_t rd;
		reg_idx_t rs1;
		reg_idx_t rs2;
		word_t    r;
		word_t    imm;
		int       wait_cycles;
		arst_n = 1'b0;
		instr_valid = 1'b0;
		instr = '0;
		repeat (10) @(posedge clk);
		arst_n <= 1'b1;
		idle(5);  // quiet period, no retires expected
		for (int i = 1; i < 32; i++) begin
			imm = (i == 1) ? 32'd32 : word_t'(rnd(4096) - 2048);  // x1 is the RAM base
			issue(OP_ADDI, reg_idx_t'(i), 5'd0, 5'd0, imm);
		end
		for (int j = 0; j < 16; j++)
			issue(OP_SW, 5'd0, 5'd1, reg_idx_t'(j + 3), word_t'(4 * j - 32));
		idle(2);
		repeat (2000) begin
			op = op_e'(rnd(14));
			rd = reg_idx_t'(rnd(31));
			if (rd != 5'd0)
				rd = rd + 5'd1;  // never x1
			rs1 = reg_idx_t'(rnd(32));
			rs2 = reg_idx_t'(rnd(32));
			r = $random(seed);
			case (op)
				OP_LW, OP_SW:     imm = word_t'(rnd(16) * 4 - 32);
				OP_SB:            imm = word_t'(rnd(64) - 32);
				OP_SH:            imm = word_t'(rnd(32) * 2 - 32);
				OP_LUI, OP_AUIPC: imm = {r[31:12], 12'b0};
				OP_JAL:           imm = {{11{r[20]}}, r[20:1], 1'b0};
				OP_BEQ, OP_BNE:   imm = {{19{r[12]}}, r[12:1], 1'b0};
				OP_ILLEGAL:       imm = r;
				default:          imm = {{20{r[11]}}, r[11:0]};
			endcase
			if (op inside {OP_LW, OP_SB, OP_SH, OP_SW})
				rs1 = 5'd1;
			if ((op == OP_BEQ || op == OP_BNE) && r[0])
				rs2 = rs1;  // force the equal case now and then
			issue(op, rd, rs1, rs2, imm);
			if (rnd(4) == 0)
				idle(1 + rnd(3));
		end
		idle(1);
		wait_cycles = 0;
		while (exp_q.size() != 0 && wait_cycles < 50) begin
			@(posedge clk);
			wait_cycles++;
		end
		assert (exp_q.size() == 0) else begin
			$display("timeout: %0d instructions never retired", exp_q.size());
			failures++;
		end
		repeat (4) @(posedge clk);
		$display("errors: %0d mismatches, %0d other failures", mismatches, failures);
		if (mismatches == 0 && failures == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

endmodule

//--- logic/rv_core.sv
module rv_core (
	input  logic             clk,
	input  logic             arst_n,
	input  logic             instr_valid,
	input  rv_pkg::word_t    instr,
	output logic             retire_valid,
	output rv_pkg::word_t    retire_pc,
	output rv_pkg::reg_idx_t retire_rd,
	output rv_pkg::word_t    retire_value,
	output rv_pkg::word_t    retire_next_pc,
	output logic             retire_illegal
);
	import rv_pkg::*;

	dec_if     dec_bus ();
	rf_read_if rf_bus ();
	mem_if     mem_bus ();

	logic     ex_valid;
	op_e      ex_op;
	reg_idx_t ex_rd;
	word_t    ex_value;
	word_t    ex_next_pc;
	word_t    ex_pc;
	word_t    cur_pc;

	inst_decode i_inst_decode (
		.clk         (clk),
		.arst_n      (arst_n),
		.instr_valid (instr_valid),
		.instr       (instr),
		.pc          (cur_pc),
		.dec         (dec_bus.source)
	);

	exec_unit i_exec_unit (
		.dec     (dec_bus.sink),
		.rf      (rf_bus.requester),
		.mem     (mem_bus.master),
		.valid   (ex_valid),
		.op      (ex_op),
		.rd      (ex_rd),
		.value   (ex_value),
		.next_pc (ex_next_pc),
		.pc      (ex_pc)
	);

	data_ram i_data_ram (
		.clk (clk),
		.mem (mem_bus.slave)
	);

	result_commit i_result_commit (
		.clk            (clk),
		.arst_n         (arst_n),
		.rf             (rf_bus.responder),
		.valid          (ex_valid),
		.op             (ex_op),
		.rd             (ex_rd),
		.value          (ex_value),
		.next_pc        (ex_next_pc),
		.pc             (ex_pc),
		.cur_pc         (cur_pc),
		.retire_valid   (retire_valid),
		.retire_pc      (retire_pc),
		.retire_rd      (retire_rd),
		.retire_value   (retire_value),
		.retire_next_pc (retire_next_pc),
		.retire_illegal (retire_illegal)
	);

endmodule

//--- logic/result_commit.sv
module result_commit (
	input  logic             clk,
	input  logic             arst_n,
	rf_read_if.responder     rf,
	input  logic             valid,
	input  rv_pkg::op_e      op,
	input  rv_pkg::reg_idx_t rd,
	input  rv_pkg::word_t    value,
	input  rv_pkg::word_t    next_pc,
	input  rv_pkg::word_t    pc,
	output rv_pkg::word_t    cur_pc,
	output logic             retire_valid,
	output rv_pkg::word_t    retire_pc,
	output rv_pkg::reg_idx_t retire_rd,
	output rv_pkg::word_t    retire_value,
	output rv_pkg::word_t    retire_next_pc,
	output logic             retire_illegal
);
	import rv_pkg::*;

	word_t    regs [1:31];  // x0 is not stored
	word_t    pc_q;
	logic     writes_rd;
	reg_idx_t wr_idx;

	always_comb begin
		case (op)
			OP_SB, OP_SH, OP_SW, OP_BEQ, OP_BNE, OP_ILLEGAL: writes_rd = 1'b0;
			default:                                         writes_rd = 1'b1;
		endcase
	end

	assign wr_idx = writes_rd ? rd : '0;

	assign rf.src1 = (rf.rs1 == '0) ? '0 : regs[rf.rs1];
	assign rf.src2 = (rf.rs2 == '0) ? '0 : regs[rf.rs2];

	// pc for an instruction strobed this cycle, so back-to-back issue sees the new pc
	assign cur_pc = valid ? next_pc : pc_q;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			pc_q <= '0;
			for (int i = 1; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (valid) begin
			pc_q <= next_pc;
			if (wr_idx != '0) begin
				regs[wr_idx] <= value;
			end
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			retire_valid <= 1'b0;
		end else begin
			retire_valid <= valid;
		end
	end

	always_ff @(posedge clk) begin
		if (valid) begin
			retire_pc      <= pc;
			retire_rd      <= wr_idx;
			retire_value   <= value;
			retire_next_pc <= next_pc;
			retire_illegal <= (op == OP_ILLEGAL);
		end
	end

	// execute continues from the committed pc
	a_pc_in_order: assert property (@(posedge clk) disable iff (!arst_n)
		valid |-> pc == pc_q);

endmodule

//--- logic/data_ram.sv
module data_ram (
	input logic clk,
	mem_if.slave mem
);
	import rv_pkg::*;

	word_t     ram [RAM_WORDS];
	ram_addr_t widx;

	// word index, upper address bits wrap
	assign widx = mem.addr[$bits(ram_addr_t)+1:2];

	assign mem.rdata = ram[widx];

	always_ff @(posedge clk) begin
		if (mem.we) begin
			for (int b = 0; b < 4; b++) begin
				if (mem.wmask[b]) begin
					ram[widx][8*b +: 8] <= mem.wdata[8*b +: 8];
				end
			end
		end
	end

endmodule

//--- logic/exec_unit.sv
module exec_unit (
	dec_if.sink                dec,
	rf_read_if.requester       rf,
	mem_if.master              mem,
	output logic               valid,
	output rv_pkg::op_e        op,
	output rv_pkg::reg_idx_t   rd,
	output rv_pkg::word_t      value,
	output rv_pkg::word_t      next_pc,
	output rv_pkg::word_t      pc
);
	import rv_pkg::*;

	word_t      pc_plus4;
	word_t      pc_plus_imm;
	word_t      src1_plus_imm;
	byte_mask_t base_mask;
	logic [7:0] mask_wide;
	logic       is_store;

	assign rf.rs1 = dec.rs1;
	assign rf.rs2 = dec.rs2;

	assign pc_plus4      = dec.pc + 32'd4;
	assign pc_plus_imm   = dec.pc + dec.imm;
	assign src1_plus_imm = rf.src1 + dec.imm;  // addi, jalr and load/store address

	// memory side
	assign is_store  = (dec.op == OP_SB) || (dec.op == OP_SH) || (dec.op == OP_SW);
	assign mem.we    = dec.valid && is_store;
	assign mem.addr  = src1_plus_imm;
	assign mem.wdata = rf.src2 << {src1_plus_imm[1:0], 3'b000};  // move to byte lane

	always_comb begin
		case (dec.op)
			OP_SB:   base_mask = 4'h1;
			OP_SH:   base_mask = 4'h3;
			OP_SW:   base_mask = 4'hf;
			default: base_mask = 4'h0;
		endcase
	end

	assign mask_wide = {4'b0, base_mask} << src1_plus_imm[1:0];
	assign mem.wmask = mask_wide[3:0];

	always_comb begin
		case (dec.op)
			OP_LUI:           value = dec.imm;
			OP_AUIPC:         value = pc_plus_imm;
			OP_JAL, OP_JALR:  value = pc_plus4;  // link address
			OP_LW:            value = mem.rdata;
			OP_ADDI:          value = src1_plus_imm;
			OP_ADD:           value = rf.src1 + rf.src2;
			OP_SUB:           value = rf.src1 - rf.src2;
			default:          value = '0;
		endcase
	end

	always_comb begin
		case (dec.op)
			OP_JAL:  next_pc = pc_plus_imm;
			OP_JALR: next_pc = {src1_plus_imm[31:1], 1'b0};
			OP_BEQ:  next_pc = (rf.src1 == rf.src2) ? pc_plus_imm : pc_plus4;
			OP_BNE:  next_pc = (rf.src1 != rf.src2) ? pc_plus_imm : pc_plus4;
			default: next_pc = pc_plus4;
		endcase
	end

	assign valid = dec.valid;
	assign op    = dec.op;
	assign rd    = dec.rd;
	assign pc    = dec.pc;

	// store mask check, settled values only
	always_comb begin
		if (mem.we) begin
			a_mask_in_word: assert final (mask_wide[7:4] == 4'h0);
		end
	end

endmodule

//--- logic/inst_decode.sv
module inst_decode (
	input  logic          clk,
	input  logic          arst_n,
	input  logic          instr_valid,
	input  rv_pkg::word_t instr,
	input  rv_pkg::word_t pc,
	dec_if.source         dec
);
	import rv_pkg::*;

	opcode_t    opcode;
	funct3_t    funct3;
	logic [6:0] funct7;
	op_e        op_d;
	word_t      imm_d;

	assign opcode = instr[6:0];
	assign funct3 = instr[14:12];
	assign funct7 = instr[31:25];

	always_comb begin
		op_d = OP_ILLEGAL;  // anything unmatched
		case (opcode)
			OPC_LUI:    op_d = OP_LUI;
			OPC_AUIPC:  op_d = OP_AUIPC;
			OPC_JAL:    op_d = OP_JAL;
			OPC_JALR:   if (funct3 == 3'b000) op_d = OP_JALR;
			OPC_LOAD:   if (funct3 == 3'b010) op_d = OP_LW;
			OPC_IMM:    if (funct3 == 3'b000) op_d = OP_ADDI;
			OPC_STORE: begin
				case (funct3)
					3'b000:  op_d = OP_SB;
					3'b001:  op_d = OP_SH;
					3'b010:  op_d = OP_SW;
					default: op_d = OP_ILLEGAL;
				endcase
			end
			OPC_REG: begin
				if (funct3 == 3'b000 && funct7 == 7'b0000000)
					op_d = OP_ADD;
				else if (funct3 == 3'b000 && funct7 == 7'b0100000)
					op_d = OP_SUB;
			end
			OPC_BRANCH: begin
				if (funct3 == 3'b000)
					op_d = OP_BEQ;
				else if (funct3 == 3'b001)
					op_d = OP_BNE;
			end
			default: op_d = OP_ILLEGAL;
		endcase
	end

	// immediate format follows the operation
	always_comb begin
		case (op_d)
			OP_LUI, OP_AUIPC:   imm_d = {instr[31:12], 12'b0};
			OP_JAL:             imm_d = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
			OP_SB, OP_SH, OP_SW: imm_d = {{20{instr[31]}}, instr[31:25], instr[11:7]};
			OP_BEQ, OP_BNE:     imm_d = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
			default:            imm_d = {{20{instr[31]}}, instr[31:20]};  // I-type
		endcase
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			dec.valid <= 1'b0;
		end else begin
			dec.valid <= instr_valid;  // one cycle per strobe
		end
	end

	always_ff @(posedge clk) begin
		if (instr_valid) begin
			dec.op  <= op_d;
			dec.rd  <= instr[11:7];
			dec.rs1 <= instr[19:15];
			dec.rs2 <= instr[24:20];
			dec.imm <= imm_d;
			dec.pc  <= pc;
		end
	end

	// an unknown word would silently decode as illegal
	a_instr_known: assert property (@(posedge clk) disable iff (!arst_n)
		instr_valid |-> !$isunknown(instr));

endmodule

//--- logic/rv_ifs.sv
// decoded instruction, decode register to execute
interface dec_if;
	import rv_pkg::*;

	logic     valid;
	op_e      op;
	reg_idx_t rd;
	reg_idx_t rs1;
	reg_idx_t rs2;
	word_t    imm;
	word_t    pc;

	modport source (output valid, op, rd, rs1, rs2, imm, pc);
	modport sink   (input valid, op, rd, rs1, rs2, imm, pc);
endinterface

// register file read ports, two operands
interface rf_read_if;
	import rv_pkg::*;

	reg_idx_t rs1;
	reg_idx_t rs2;
	word_t    src1;
	word_t    src2;

	modport requester (output rs1, rs2, input src1, src2);
	modport responder (input rs1, rs2, output src1, src2);
endinterface

// data memory port
interface mem_if;
	import rv_pkg::*;

	logic       we;
	word_t      addr;
	word_t      wdata;
	byte_mask_t wmask;
	word_t      rdata;

	modport master (output we, addr, wdata, wmask, input rdata);
	modport slave  (input we, addr, wdata, wmask, output rdata);
endinterface

//--- logic/rv_pkg.sv
package rv_pkg;

	typedef logic [31:0] word_t;     // data, address or instruction
	typedef logic [4:0]  reg_idx_t;
	typedef logic [6:0]  opcode_t;
	typedef logic [2:0]  funct3_t;
	typedef logic [3:0]  byte_mask_t;

	typedef enum logic [3:0] {
		OP_LUI,
		OP_AUIPC,
		OP_JAL,
		OP_JALR,
		OP_LW,
		OP_SB,
		OP_SH,
		OP_SW,
		OP_ADDI,
		OP_ADD,
		OP_SUB,
		OP_BEQ,
		OP_BNE,
		OP_ILLEGAL
	} op_e;

	// major opcodes
	localparam opcode_t OPC_LUI    = 7'b0110111;
	localparam opcode_t OPC_AUIPC  = 7'b0010111;
	localparam opcode_t OPC_JAL    = 7'b1101111;
	localparam opcode_t OPC_JALR   = 7'b1100111;
	localparam opcode_t OPC_LOAD   = 7'b0000011;
	localparam opcode_t OPC_STORE  = 7'b0100011;
	localparam opcode_t OPC_IMM    = 7'b0010011;
	localparam opcode_t OPC_REG    = 7'b0110011;
	localparam opcode_t OPC_BRANCH = 7'b1100011;

	localparam int RAM_WORDS = 256;  // 1 KiB

	typedef logic [$clog2(RAM_WORDS)-1:0] ram_addr_t;

endpackage
